// File: project.f
rtl/mipsPkg.sv
rtl/fetchStage.sv
rtl/registerFile.sv
rtl/hazardUnit.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memWriteback.sv
rtl/mipsPipeline.sv
tests/mipsPipeline_checker.sv
tests/mipsPipelineTb.sv

// File: run.sh
#!/usr/bin/env bash
# compile with Verilator, run, and decide on the pass line in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module mipsPipelineTb \
    -f project.f \
    -Mdir obj_dir \
    && ./obj_dir/VmipsPipelineTb +verilator+error+limit+1000 \
        | tee /dev/stderr | grep -q "Simulation PASSED" \
    && echo "run.sh: pass" \
    || { echo "run.sh: fail"; exit 1; }

// File: tests/mipsPipelineTb.sv
`timescale 1ns/1ns

module mipsPipelineTb;
    import mipsPkg::*;

    localparam wordAddrT poisonAddr = 30'd32;

    logic     clk;
    logic     rst_n;
    wordAddrT icacheAddr;
    wordT     icacheRdata;
    logic     icacheStall;
    dataReqT  dcacheReq;
    wordT     dcacheRdata;
    logic     dcacheStall;

    wordT     prog [64];
    wordT     dmem [256];
    wordAddrT expAddr [$];
    wordT     expData [$];
    string    testNames [5];
    int       errs [5];
    int       seed;
    int       storeIdx;
    logic     stallsOn;
    logic     stallPhase;
    logic     timedOut;
    int       checkerSeen;
    int       failedTests;
    int       testsRun;

    mipsPipeline #(
        .resetPc(32'd0),
        .regCount(32)
    ) uut (
        .clk, .rst_n, .icacheAddr, .icacheRdata, .icacheStall,
        .dcacheReq, .dcacheRdata, .dcacheStall
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // program and memories
    ////////////////////////////////////////

    function automatic wordT encodeR(functT fn, regIdxT rd, regIdxT rs, regIdxT rt);
        return {opRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic wordT encodeI(opcodeT op, regIdxT rt, regIdxT rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic loadProgram();
        for (int i = 0; i < 64; i++) begin
            prog[i] = '0;
        end
        // dependent chain where each result feeds the next instruction
        prog[0]  = encodeI(opAddi, 5'd1, 5'd0, 16'd5);
        prog[1]  = encodeI(opAddi, 5'd2, 5'd1, 16'd7);
        prog[2]  = encodeR(fnAdd, 5'd3, 5'd1, 5'd2);
        prog[3]  = encodeR(fnSub, 5'd4, 5'd3, 5'd2);
        prog[4]  = encodeR(fnAnd, 5'd5, 5'd4, 5'd3);
        prog[5]  = encodeR(fnOr, 5'd6, 5'd5, 5'd2);
        prog[6]  = encodeR(fnSlt, 5'd7, 5'd1, 5'd6);
        prog[7]  = encodeI(opSw, 5'd7, 5'd0, 16'd8);
        prog[8]  = encodeI(opSw, 5'd6, 5'd0, 16'd4);
        prog[9]  = encodeI(opSw, 5'd3, 5'd0, 16'd0);
        // load then immediate use
        prog[10] = encodeI(opLw, 5'd8, 5'd0, 16'd64);
        prog[11] = encodeR(fnAdd, 5'd9, 5'd8, 5'd2);
        prog[12] = encodeI(opSw, 5'd9, 5'd0, 16'd12);
        // taken branch over three poison stores
        prog[13] = encodeI(opBeq, 5'd1, 5'd1, 16'd3);
        prog[14] = encodeI(opSw, 5'd1, 5'd0, 16'd128);
        prog[15] = encodeI(opSw, 5'd1, 5'd0, 16'd128);
        prog[16] = encodeI(opSw, 5'd1, 5'd0, 16'd128);
        prog[17] = encodeI(opSw, 5'd2, 5'd0, 16'd16);
        // halt by branching to itself
        prog[18] = encodeI(opBeq, 5'd0, 5'd0, 16'hffff);
    endtask

    task automatic fillDataMem();
        for (int i = 0; i < 256; i++) begin
            dmem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h3c, 8'hc5};
        end
    endtask

    // instruction-level model that collects the stores in program order
    task automatic buildExpected();
        wordT   modelRegs [32];
        wordT   pc;
        wordT   instr;
        wordT   a;
        wordT   b;
        wordT   imm;
        wordT   addr;
        regIdxT rt;
        regIdxT rd;
        logic   halted;
        int     steps;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        pc = '0;
        halted = 1'b0;
        steps = 0;
        while (!halted && steps < 200) begin
            instr = prog[pc[7:2]];
            a = modelRegs[instr[25:21]];
            b = modelRegs[instr[20:16]];
            rt = instr[20:16];
            rd = instr[15:11];
            imm = {{16{instr[15]}}, instr[15:0]};
            addr = a + imm;
            pc = pc + 32'd4;
            case (instr[31:26])
                opRType: begin
                    case (instr[5:0])
                        fnAdd: modelRegs[rd] = a + b;
                        fnSub: modelRegs[rd] = a - b;
                        fnAnd: modelRegs[rd] = a & b;
                        fnOr:  modelRegs[rd] = a | b;
                        fnSlt: modelRegs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: ;
                    endcase
                end
                opAddi: modelRegs[rt] = addr;
                opLw:   modelRegs[rt] = dmem[addr[9:2]];
                opSw: begin
                    expAddr.push_back(addr[31:2]);
                    expData.push_back(b);
                end
                opBeq: begin
                    if (a == b) begin
                        halted = (instr[15:0] == 16'hffff);
                        pc = pc + {imm[29:0], 2'b00};
                    end
                end
                default: ;
            endcase
            modelRegs[0] = '0;
            steps++;
        end
    endtask

    ////////////////////////////////////////
    // cache models and store monitor
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (stallsOn) begin
            icacheStall = ($random(seed) & 32'h3) == 32'h0;
            dcacheStall = ($random(seed) & 32'h3) == 32'h0;
        end else begin
            icacheStall = 1'b0;
            dcacheStall = 1'b0;
        end
        icacheRdata = prog[icacheAddr[5:0]];
        dcacheRdata = dmem[dcacheReq.addr[7:0]];
    end

    function automatic int testOf(int idx);
        if (stallPhase) begin
            return 4;
        end else if (idx < 3) begin
            return 1;
        end else if (idx == 3) begin
            return 2;
        end
        return 3;
    endfunction

    // a store is taken only on an edge without freeze
    always @(posedge clk) begin
        if (rst_n && dcacheReq.write && !icacheStall && !dcacheStall) begin
            dmem[dcacheReq.addr[7:0]] = dcacheReq.wdata;
            assert (dcacheReq.addr != poisonAddr) else begin
                $display("%s: a store reached the poison address", testNames[testOf(storeIdx)]);
                errs[testOf(storeIdx)]++;
            end
            if (storeIdx >= expAddr.size()) begin
                $display("%s: more stores than the program makes", testNames[testOf(storeIdx)]);
                errs[testOf(storeIdx)]++;
            end else begin
                assert (dcacheReq.addr == expAddr[storeIdx] &&
                        dcacheReq.wdata == expData[storeIdx]) else begin
                    $display("ERR %s: expected addr %h data %h, actual addr %h data %h",
                             testNames[testOf(storeIdx)], expAddr[storeIdx],
                             expData[storeIdx], dcacheReq.addr, dcacheReq.wdata);
                    errs[testOf(storeIdx)]++;
                end
            end
            storeIdx++;
        end
    end

    ////////////////////////////////////////
    // phases and reporting
    ////////////////////////////////////////

    task automatic runPhase(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        stallsOn = 1'b0;
        rst_n = 1'b0;
        storeIdx = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        stallsOn = stallPhase;
        while (storeIdx < expAddr.size() && cycles < 400) begin
            @(negedge clk);
            cycles++;
        end
        if (storeIdx < expAddr.size()) begin
            $display("%s did not finish, %0d of %0d stores seen", name, storeIdx, expAddr.size());
            timedOut = 1'b1;
        end else begin
            // let the halt loop spin so late stores show up
            cycles = 0;
            while (cycles < 20) begin
                @(negedge clk);
                cycles++;
            end
        end
        stallsOn = 1'b0;
    endtask

    task automatic reportTest(int t);
        testsRun++;
        if (errs[t] == 0) begin
            $display("test %s: ok", testNames[t]);
        end else begin
            $display("test %s: %0d errors", testNames[t], errs[t]);
            failedTests++;
        end
    endtask

    initial begin
        rst_n = 1'b0;
        icacheRdata = '0;
        dcacheRdata = '0;
        icacheStall = 1'b0;
        dcacheStall = 1'b0;
        stallsOn = 1'b0;
        stallPhase = 1'b0;
        timedOut = 1'b0;
        storeIdx = 0;
        seed = 76172;
        failedTests = 0;
        testsRun = 0;
        testNames = '{"reset", "aluForward", "loadUse", "takenBranch", "cacheStall"};
        errs = '{0, 0, 0, 0, 0};
        loadProgram();
        fillDataMem();
        buildExpected();

        runPhase("plain run");
        // reset values are checked by the bound checker
        checkerSeen = uut.checks.failCount;
        errs[0] = checkerSeen;
        for (int t = 0; t < 4; t++) begin
            reportTest(t);
        end

        if (!timedOut) begin
            stallPhase = 1'b1;
            fillDataMem();
            runPhase("stalled run");
            errs[4] += uut.checks.failCount - checkerSeen;
            reportTest(4);
        end

        $display("tests run %0d, failed %0d, timeouts %0d",
                 testsRun, failedTests, timedOut ? 1 : 0);
        if (failedTests == 0 && !timedOut) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: tests/mipsPipeline_checker.sv
`timescale 1ns/1ns

module mipsPipeline_checker #(
    parameter mipsPkg::wordT resetPc = '0
) (
    input logic              clk,
    input logic              rst_n,
    input mipsPkg::wordAddrT icacheAddr,
    input logic              icacheStall,
    input mipsPkg::dataReqT  dcacheReq,
    input logic              dcacheStall
);
    import mipsPkg::*;

    int   failCount = 0;
    logic resetState;

    assign resetState = !dcacheReq.read && !dcacheReq.write && icacheAddr == resetPc[31:2];

    // during reset and at the first edge after it
    resetValues: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> resetState)
        else begin
            failCount++;
            $error("cache ports not at their reset values");
        end

    // a frozen pipeline keeps both cache requests steady
    stallHolds: assert property (@(posedge clk) disable iff (!rst_n)
        (icacheStall || dcacheStall) |=> ($stable(dcacheReq) && $stable(icacheAddr)))
        else begin
            failCount++;
            $error("cache request moved while a stall was high");
        end

    readWriteExclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dcacheReq.read && dcacheReq.write))
        else begin
            failCount++;
            $error("data cache read and write requested together");
        end

endmodule

bind mipsPipeline mipsPipeline_checker #(.resetPc(resetPc)) checks (
    .clk(clk),
    .rst_n(rst_n),
    .icacheAddr(icacheAddr),
    .icacheStall(icacheStall),
    .dcacheReq(dcacheReq),
    .dcacheStall(dcacheStall)
);

// File: rtl/mipsPipeline.sv
`timescale 1ns/1ns

module mipsPipeline #(
    parameter mipsPkg::wordT resetPc  = '0,
    parameter int            regCount = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    output mipsPkg::wordAddrT icacheAddr,
    input  mipsPkg::wordT     icacheRdata,
    input  logic              icacheStall,
    output mipsPkg::dataReqT  dcacheReq,
    input  mipsPkg::wordT     dcacheRdata,
    input  logic              dcacheStall
);
    import mipsPkg::*;

    logic   freeze;
    logic   decStall;
    logic   flushTaken;
    logic   branchTaken;
    wordT   branchTarget;
    wordT   ifInstr;
    wordT   ifPcPlus4;
    regIdxT readIdxA;
    regIdxT readIdxB;
    wordT   readA;
    wordT   readB;
    idExT   idExOut;
    exMemT  exMemOut;
    memWbT  memWbOut;
    wordT   wbData;
    logic   wbEn;
    regIdxT wbIdx;

    // either cache stalling freezes the whole pipeline
    assign freeze = icacheStall | dcacheStall;

    ////////////////////////////////////////
    // input side
    ////////////////////////////////////////

    fetchStage #(
        .resetPc(resetPc)
    ) fetch (
        .clk, .rst_n, .freeze, .decStall, .flushTaken,
        .branchTaken, .branchTarget, .icacheRdata,
        .icacheAddr, .ifInstr, .ifPcPlus4
    );

    ////////////////////////////////////////
    // decode, hazards, execute
    ////////////////////////////////////////

    hazardUnit hazard (
        .ifInstr, .idExOut, .branchTaken, .decStall, .flushTaken
    );

    registerFile #(
        .regCount(regCount)
    ) regFile (
        .clk, .rst_n, .readIdxA, .readIdxB, .readA, .readB,
        .writeEn(wbEn), .writeIdx(wbIdx), .writeData(wbData)
    );

    decodeStage decode (
        .clk, .rst_n, .freeze, .decStall, .flushTaken,
        .ifInstr, .ifPcPlus4, .readA, .readB,
        .readIdxA, .readIdxB, .idExOut
    );

    executeStage execute (
        .clk, .rst_n, .freeze, .flushTaken, .idExOut, .memWbOut,
        .wbData, .exMemOut, .branchTaken, .branchTarget
    );

    // output side
    memWriteback memWb (
        .clk, .rst_n, .freeze, .exMemOut, .dcacheRdata,
        .dcacheReq, .memWbOut, .wbData, .wbEn, .wbIdx
    );

endmodule

// File: rtl/memWriteback.sv
`timescale 1ns/1ns

module memWriteback (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             freeze,
    input  mipsPkg::exMemT   exMemOut,
    input  mipsPkg::wordT    dcacheRdata,
    output mipsPkg::dataReqT dcacheReq,
    output mipsPkg::memWbT   memWbOut,
    output mipsPkg::wordT    wbData,
    output logic             wbEn,
    output mipsPkg::regIdxT  wbIdx
);
    import mipsPkg::*;

    memWbT memWbNext;

    // data cache request straight from EX/MEM
    always_comb begin
        dcacheReq.read  = exMemOut.ctrl.memRead;
        dcacheReq.write = exMemOut.ctrl.memWrite;
        dcacheReq.addr  = exMemOut.aluResult[31:2];
        dcacheReq.wdata = exMemOut.storeData;
    end

    always_comb begin
        memWbNext.regWrite  = exMemOut.ctrl.regWrite;
        memWbNext.memRead   = exMemOut.ctrl.memRead;
        memWbNext.aluResult = exMemOut.aluResult;
        memWbNext.loadData  = dcacheRdata;
        memWbNext.wIdx      = exMemOut.wIdx;
    end

    // MEM/WB register, load data captured once the stall drops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memWbOut <= '0;
        end else if (!freeze) begin
            memWbOut <= memWbNext;
        end
    end

    // write-back select
    assign wbData = memWbOut.memRead ? memWbOut.loadData : memWbOut.aluResult;
    assign wbEn   = memWbOut.regWrite;
    assign wbIdx  = memWbOut.wIdx;

endmodule

// File: rtl/executeStage.sv
`timescale 1ns/1ns

module executeStage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           freeze,
    input  logic           flushTaken,
    input  mipsPkg::idExT  idExOut,
    input  mipsPkg::memWbT memWbOut,
    input  mipsPkg::wordT  wbData,
    output mipsPkg::exMemT exMemOut,
    output logic           branchTaken,
    output mipsPkg::wordT  branchTarget
);
    import mipsPkg::*;

    wordT  fwdA;
    wordT  fwdB;
    wordT  aluB;
    wordT  aluResult;
    aluOpT aluOp;
    exMemT exMemNext;

    ////////////////////////////////////////
    // forwarding
    ////////////////////////////////////////

    // EX/MEM is younger than MEM/WB, so it wins
    function automatic wordT pickOperand(regIdxT src, wordT regVal);
        if (exMemOut.ctrl.regWrite && exMemOut.wIdx != '0 && exMemOut.wIdx == src) begin
            return exMemOut.aluResult;
        end else if (memWbOut.regWrite && memWbOut.wIdx != '0 && memWbOut.wIdx == src) begin
            return wbData;
        end
        return regVal;
    endfunction

    always_comb begin
        fwdA = pickOperand(idExOut.rsIdx, idExOut.opA);
        fwdB = pickOperand(idExOut.rtIdx, idExOut.opB);
    end

    ////////////////////////////////////////
    // ALU control and ALU
    ////////////////////////////////////////

    always_comb begin
        aluOp = aluAdd;
        if (idExOut.ctrl.isRType) begin
            case (idExOut.funct)
                fnAdd:   aluOp = aluAdd;
                fnSub:   aluOp = aluSub;
                fnAnd:   aluOp = aluAnd;
                fnOr:    aluOp = aluOr;
                fnSlt:   aluOp = aluSlt;
                default: aluOp = aluAdd;
            endcase
        end else if (idExOut.ctrl.branch) begin
            // beq compares by subtraction
            aluOp = aluSub;
        end
    end

    assign aluB = idExOut.ctrl.aluSrcImm ? idExOut.imm : fwdB;

    always_comb begin
        case (aluOp)
            aluAdd:  aluResult = fwdA + aluB;
            aluSub:  aluResult = fwdA - aluB;
            aluAnd:  aluResult = fwdA & aluB;
            aluOr:   aluResult = fwdA | aluB;
            aluSlt:  aluResult = {31'd0, $signed(fwdA) < $signed(aluB)};
            default: aluResult = fwdA + aluB;
        endcase
    end

    always_comb begin
        exMemNext.ctrl      = idExOut.ctrl;
        exMemNext.zero      = aluResult == '0;
        exMemNext.aluResult = aluResult;
        // store data is the forwarded Rt, not the immediate
        exMemNext.storeData = fwdB;
        exMemNext.wIdx      = idExOut.wIdx;
        exMemNext.brTarget  = idExOut.brTarget;
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exMemOut <= '0;
        end else if (!freeze) begin
            if (flushTaken) begin
                exMemOut <= '0;
            end else begin
                exMemOut <= exMemNext;
            end
        end
    end

    // branch resolves in MEM
    assign branchTaken  = exMemOut.ctrl.branch & exMemOut.zero;
    assign branchTarget = exMemOut.brTarget;

endmodule

// File: rtl/decodeStage.sv
`timescale 1ns/1ns

module decodeStage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            freeze,
    input  logic            decStall,
    input  logic            flushTaken,
    input  mipsPkg::wordT   ifInstr,
    input  mipsPkg::wordT   ifPcPlus4,
    input  mipsPkg::wordT   readA,
    input  mipsPkg::wordT   readB,
    output mipsPkg::regIdxT readIdxA,
    output mipsPkg::regIdxT readIdxB,
    output mipsPkg::idExT   idExOut
);
    import mipsPkg::*;

    opcodeT opcode;
    regIdxT rsIdx;
    regIdxT rtIdx;
    regIdxT rdIdx;
    wordT   immExt;
    ctrlT   ctrl;
    idExT   idExNext;

    ////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////

    assign opcode = ifInstr[31:26];
    assign rsIdx  = ifInstr[25:21];
    assign rtIdx  = ifInstr[20:16];
    assign rdIdx  = ifInstr[15:11];

    // register file is read with the raw source fields
    assign readIdxA = rsIdx;
    assign readIdxB = rtIdx;

    assign immExt = {{16{ifInstr[15]}}, ifInstr[15:0]};

    ////////////////////////////////////////
    // main control
    ////////////////////////////////////////

    always_comb begin
        ctrl = '0;
        case (opcode)
            opRType: begin
                ctrl.regWrite = 1'b1;
                ctrl.isRType  = 1'b1;
            end
            opAddi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opLw: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opSw: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opBeq: begin
                ctrl.branch = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    always_comb begin
        // bubble on load-use: data moves on, control is dropped
        idExNext.ctrl  = decStall ? ctrlT'('0) : ctrl;
        idExNext.funct = ifInstr[5:0];
        idExNext.rsIdx = rsIdx;
        idExNext.rtIdx = rtIdx;
        // Rd for R-type, Rt for the immediate forms
        idExNext.wIdx  = ctrl.isRType ? rdIdx : rtIdx;
        idExNext.opA   = readA;
        idExNext.opB   = readB;
        idExNext.imm   = immExt;
        idExNext.brTarget = ifPcPlus4 + {immExt[29:0], 2'b00};
    end

    // ID/EX register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idExOut <= '0;
        end else if (!freeze) begin
            if (flushTaken) begin
                idExOut <= '0;
            end else begin
                idExOut <= idExNext;
            end
        end
    end

endmodule

// File: rtl/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit (
    input  mipsPkg::wordT ifInstr,
    input  mipsPkg::idExT idExOut,
    input  logic          branchTaken,
    output logic          decStall,
    output logic          flushTaken
);
    import mipsPkg::*;

    opcodeT opcode;
    regIdxT rsIdx;
    regIdxT rtIdx;
    logic   readsRs;
    logic   readsRt;
    logic   rsHit;
    logic   rtHit;

    assign opcode = ifInstr[31:26];
    assign rsIdx  = ifInstr[25:21];
    assign rtIdx  = ifInstr[20:16];

    // which source fields the instruction in IF/ID really uses
    always_comb begin
        case (opcode)
            opRType, opSw, opBeq: begin
                readsRs = 1'b1;
                readsRt = 1'b1;
            end
            opAddi, opLw: begin
                readsRs = 1'b1;
                readsRt = 1'b0;
            end
            default: begin
                readsRs = 1'b0;
                readsRt = 1'b0;
            end
        endcase
    end

    // load in ID/EX feeding the next instruction
    assign rsHit = readsRs && rsIdx == idExOut.wIdx;
    assign rtHit = readsRt && rtIdx == idExOut.wIdx;

    // a taken branch discards both instructions, so no bubble is needed then
    assign decStall = idExOut.ctrl.memRead && idExOut.wIdx != '0 && (rsHit || rtHit)
                      && !branchTaken;

    assign flushTaken = branchTaken;

endmodule

// File: rtl/registerFile.sv
`timescale 1ns/1ns

module registerFile #(
    parameter int regCount = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  mipsPkg::regIdxT readIdxA,
    input  mipsPkg::regIdxT readIdxB,
    output mipsPkg::wordT   readA,
    output mipsPkg::wordT   readB,
    input  logic            writeEn,
    input  mipsPkg::regIdxT writeIdx,
    input  mipsPkg::wordT   writeData
);
    import mipsPkg::*;

    wordT regs [regCount];

    // r0 reads zero, a same-cycle write is passed through
    function automatic wordT readPort(regIdxT idx);
        if (idx == '0) begin
            return '0;
        end else if (writeEn && writeIdx == idx) begin
            return writeData;
        end
        return regs[idx];
    endfunction

    always_comb begin
        readA = readPort(readIdxA);
        readB = readPort(readIdxB);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeIdx != '0) begin
            regs[writeIdx] <= writeData;
        end
    end

endmodule

// File: rtl/fetchStage.sv
`timescale 1ns/1ns

module fetchStage #(
    parameter mipsPkg::wordT resetPc = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              freeze,
    input  logic              decStall,
    input  logic              flushTaken,
    input  logic              branchTaken,
    input  mipsPkg::wordT     branchTarget,
    input  mipsPkg::wordT     icacheRdata,
    output mipsPkg::wordAddrT icacheAddr,
    output mipsPkg::wordT     ifInstr,
    output mipsPkg::wordT     ifPcPlus4
);
    import mipsPkg::*;

    wordT pc;
    wordT pcPlus4;
    wordT pcNext;
    logic hold;

    assign hold       = freeze | decStall;
    assign pcPlus4    = pc + 32'd4;
    assign pcNext     = branchTaken ? branchTarget : pcPlus4;
    assign icacheAddr = pc[31:2];

    // program counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= resetPc;
        end else if (!hold) begin
            pc <= pcNext;
        end
    end

    // IF/ID register, instruction word taken straight from the cache
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifInstr   <= '0;
            ifPcPlus4 <= '0;
        end else if (!hold) begin
            if (flushTaken) begin
                ifInstr   <= '0;
                ifPcPlus4 <= '0;
            end else begin
                ifInstr   <= icacheRdata;
                ifPcPlus4 <= pcPlus4;
            end
        end
    end

endmodule

// File: rtl/mipsPkg.sv
package mipsPkg;

    ////////////////////////////////////////
    // widths with a meaning
    ////////////////////////////////////////

    typedef logic [31:0] wordT;
    typedef logic [29:0] wordAddrT;
    typedef logic [4:0]  regIdxT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;

    // primary opcodes
    localparam opcodeT opRType = 6'h00;
    localparam opcodeT opAddi  = 6'h08;
    localparam opcodeT opLw    = 6'h23;
    localparam opcodeT opSw    = 6'h2b;
    localparam opcodeT opBeq   = 6'h04;

    // R-type function codes
    localparam functT fnAdd = 6'h20;
    localparam functT fnSub = 6'h22;
    localparam functT fnAnd = 6'h24;
    localparam functT fnOr  = 6'h25;
    localparam functT fnSlt = 6'h2a;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    ////////////////////////////////////////
    // pipeline register contents
    ////////////////////////////////////////

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic branch;
        logic aluSrcImm;
        logic isRType;
    } ctrlT;

    typedef struct packed {
        ctrlT   ctrl;
        functT  funct;
        regIdxT rsIdx;
        regIdxT rtIdx;
        regIdxT wIdx;
        wordT   opA;
        wordT   opB;
        wordT   imm;
        wordT   brTarget;
    } idExT;

    typedef struct packed {
        ctrlT   ctrl;
        logic   zero;
        wordT   aluResult;
        wordT   storeData;
        regIdxT wIdx;
        wordT   brTarget;
    } exMemT;

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        wordT   aluResult;
        wordT   loadData;
        regIdxT wIdx;
    } memWbT;

    // data cache request, 64 bits
    typedef struct packed {
        logic     read;
        logic     write;
        wordAddrT addr;
        wordT     wdata;
    } dataReqT;

endpackage
